// File: hw/fpCvtPkg.sv
/*
  Shared items of the float to integer conversion unit
  Opcode enum, operand and result widths, format field widths, exponent biases
*/

`default_nettype none

package fpCvtPkg;

  // ##############################
  // Operations
  // ##############################

  typedef enum logic [2:0] {
    opSngToI32 = 3'd0,
    opSngToI64 = 3'd1,
    opDblToI32 = 3'd2,
    opDblToI64 = 3'd3,
    opExtToI32 = 3'd4,
    opExtToI64 = 3'd5,
    opRawToI64 = 3'd6
  } cvtOpE;

  // ##############################
  // Widths
  // ##############################

  localparam int OPND_W = 80;   // Extended operand, smaller formats sit in the low bits
  localparam int RES_W  = 64;

  // Single precision fields
  localparam int SNG_EXP_W = 8;
  localparam int SNG_MAN_W = 23;

  // Double precision fields
  localparam int DBL_EXP_W = 11;
  localparam int DBL_MAN_W = 52;

  // Extended precision, mantissa has explicit integer bit
  localparam int EXT_EXP_W = 15;
  localparam int EXT_MAN_W = 64;

  // ##############################
  // Exponent biases
  // ##############################

  localparam int SNG_BIAS = 127;
  localparam int DBL_BIAS = 1023;
  localparam int EXT_BIAS = 16383;  // Internal exponent is always in this bias

endpackage

`default_nettype wire

// File: hw/cvtIssueCtrl.sv
/*
  Issue control of the conversion unit
  Opcode decode to format flags, valid and 32-bit flag pipe under stall
*/

`timescale 1ns/1ns
`default_nettype none

module cvtIssueCtrl
  import fpCvtPkg::*;
(
  input  logic  clk,
  input  logic  rst,
  input  logic  valid,
  input  logic  stall,
  input  cvtOpE op,
  output logic  isSng,
  output logic  isDbl,
  output logic  isExt,
  output logic  isRaw,
  output logic  is32Out,
  output logic  resValid
);

  logic is32;
  logic vldQ1;
  logic vldQ2;
  logic is32Q1;

  // ##############################
  // Opcode decode
  // ##############################

  always_comb begin
    isSng = 1'b0;
    isDbl = 1'b0;
    isExt = 1'b0;
    isRaw = 1'b0;
    is32  = 1'b0;
    case (op)
      opSngToI32: begin isSng = 1'b1; is32 = 1'b1; end
      opSngToI64: isSng = 1'b1;
      opDblToI32: begin isDbl = 1'b1; is32 = 1'b1; end
      opDblToI64: isDbl = 1'b1;
      opExtToI32: begin isExt = 1'b1; is32 = 1'b1; end
      opExtToI64: isExt = 1'b1;
      opRawToI64: isRaw = 1'b1;
      default:    ;  // Unused encoding, no format selected
    endcase
  end

  // ##############################
  // Valid pipe
  // ##############################

  // Same enable as the shifter stages, so flags stay aligned with data
  always_ff @(posedge clk) begin
    if (rst) begin
      vldQ1  <= 1'b0;
      vldQ2  <= 1'b0;
      is32Q1 <= 1'b0;
    end else if (!stall) begin
      vldQ1  <= valid;
      is32Q1 <= is32;   // Used by shifter stage 2
      vldQ2  <= vldQ1;
    end
  end

  assign resValid = vldQ2;
  assign is32Out  = is32Q1;

  // Unpack relies on exactly one format per accepted operation
  assert property (@(posedge clk) disable iff (rst)
    valid |-> $onehot({isSng, isDbl, isExt, isRaw}));

  // A frozen pipe must not complete anything
  assert property (@(posedge clk) disable iff (rst)
    stall |=> !$rose(resValid));

endmodule

`default_nettype wire

// File: hw/fpOperandUnpack.sv
/*
  Operand unpack for float to integer conversion
  Sign, mantissa with hidden one, rebiased exponent, shift amount, range flags
*/

`timescale 1ns/1ns
`default_nettype none

module fpOperandUnpack
  import fpCvtPkg::*;
(
  input  logic [OPND_W-1:0]    operand,
  input  logic                 isSng,
  input  logic                 isDbl,
  input  logic                 isExt,
  input  logic                 isRaw,
  output logic                 sign,
  output logic [EXT_MAN_W-1:0] mant,
  output logic [6:0]           rshift,
  output logic                 tooBig,
  output logic                 tooSmall
);

  localparam int SNG_PAD = EXT_MAN_W - 1 - SNG_MAN_W;  // 40 zeros below single fraction
  localparam int DBL_PAD = EXT_MAN_W - 1 - DBL_MAN_W;  // 11 zeros below double fraction

  logic [EXT_EXP_W-1:0] exp15;     // Exponent in extended bias
  logic                 expZero;
  logic                 expOnes;
  logic [EXT_EXP_W+1:0] unb;       // Unbiased exponent, MSB is the sign

  // ##############################
  // Field extraction
  // ##############################

  always_comb begin
    sign    = 1'b0;
    mant    = operand[EXT_MAN_W-1:0];  // Raw passes the low bits as they are
    exp15   = '0;
    expZero = 1'b0;
    expOnes = 1'b0;
    if (isSng) begin
      sign    = operand[SNG_EXP_W+SNG_MAN_W];
      exp15   = EXT_EXP_W'(operand[SNG_MAN_W +: SNG_EXP_W]) + EXT_EXP_W'(EXT_BIAS - SNG_BIAS);
      expZero = (operand[SNG_MAN_W +: SNG_EXP_W] == '0);
      expOnes = &operand[SNG_MAN_W +: SNG_EXP_W];
      mant    = {1'b1, operand[SNG_MAN_W-1:0], {SNG_PAD{1'b0}}};
    end else if (isDbl) begin
      sign    = operand[DBL_EXP_W+DBL_MAN_W];
      exp15   = EXT_EXP_W'(operand[DBL_MAN_W +: DBL_EXP_W]) + EXT_EXP_W'(EXT_BIAS - DBL_BIAS);
      expZero = (operand[DBL_MAN_W +: DBL_EXP_W] == '0);
      expOnes = &operand[DBL_MAN_W +: DBL_EXP_W];
      mant    = {1'b1, operand[DBL_MAN_W-1:0], {DBL_PAD{1'b0}}};
    end else if (isExt) begin
      sign    = operand[OPND_W-1];
      exp15   = operand[EXT_MAN_W +: EXT_EXP_W];  // Already in extended bias
      expZero = (exp15 == '0);
      expOnes = &exp15;
    end
    if (expZero) begin
      mant = '0;  // Denormals count as zero
    end
  end

  assign unb = {2'b00, exp15} - (EXT_EXP_W+2)'(EXT_BIAS);

  // ##############################
  // Shift amount and range
  // ##############################

  // rshift = 63 - unb, only meaningful for 0 <= unb <= 62
  always_comb begin
    tooBig   = 1'b0;
    tooSmall = 1'b0;
    rshift   = 7'd0;
    if (!isRaw && !expZero) begin
      if (expOnes || (!unb[EXT_EXP_W+1] && unb >= (EXT_EXP_W+2)'(63))) begin
        tooBig = 1'b1;  // Inf, NaN or magnitude of 2^63 and up
      end else if (unb[EXT_EXP_W+1]) begin
        tooSmall = 1'b1;
        rshift   = 7'd64;  // Clamped
      end else begin
        rshift = {1'b0, ~unb[5:0]};
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/fpToIntShifter.sv
/*
  Conversion datapath, two stages
  Two's complement, coarse byte shift, fine bit shift, result select and 32-bit mask
*/

`timescale 1ns/1ns
`default_nettype none

module fpToIntShifter
  import fpCvtPkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             stall,
  input  logic             is32,      // Aligned with stage 1 registers
  input  logic             sign,
  input  logic [RES_W-1:0] mant,
  input  logic [6:0]       rshift,
  input  logic             tooBig,
  input  logic             tooSmall,
  output logic [RES_W-1:0] result,
  output logic             overflow
);

  localparam int WIDE_W = RES_W + 8;  // Room for the bits the fine shift still pulls in

  logic [RES_W:0]           mag;
  logic [RES_W:0]           twos;
  logic signed [WIDE_W-1:0] wide;
  logic signed [WIDE_W-1:0] coarse;

  logic signed [WIDE_W-1:0] coarseQ;
  logic [2:0]               fineQ;
  logic                     signQ;
  logic                     bigQ;
  logic                     smallQ;

  logic signed [WIDE_W-1:0] fine;
  logic [RES_W-1:0]         resNext;
  logic                     ovfNext;

  // ##############################
  // Stage 1
  // ##############################

  // 65 bits so that a full 64-bit mantissa still negates cleanly
  assign mag  = {1'b0, mant};
  assign twos = sign ? (~mag + (RES_W+1)'(1)) : mag;

  // Fill from the two's complement MSB, so negative zero stays zero
  assign wide   = {{(WIDE_W-RES_W-1){twos[RES_W]}}, twos};
  assign coarse = wide >>> {rshift[5:3], 3'b000};  // Byte steps

  always_ff @(posedge clk) begin
    if (rst) begin
      bigQ   <= 1'b0;
      smallQ <= 1'b0;
    end else if (!stall) begin
      bigQ   <= tooBig;
      smallQ <= tooSmall | rshift[6];  // Shift of 64 leaves only the fill
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      coarseQ <= coarse;
      fineQ   <= rshift[2:0];
      signQ   <= sign;
    end
  end

  // ##############################
  // Stage 2
  // ##############################

  assign fine = coarseQ >>> fineQ;  // Bit steps, 0 to 7

  always_comb begin
    ovfNext = 1'b0;
    if (bigQ) begin
      resNext = '0;
      ovfNext = 1'b1;
    end else if (smallQ) begin
      resNext = {RES_W{signQ}};  // Floor of a fraction is 0 or -1
    end else begin
      resNext = fine[RES_W-1:0];
    end
    // 32-bit ops keep only the low word
    if (is32) begin
      resNext[RES_W-1:RES_W/2] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result   <= '0;
      overflow <= 1'b0;
    end else if (!stall) begin
      result   <= resNext;
      overflow <= ovfNext;
    end
  end

  // Unpack never flags an operand as both out of range high and low
  assert property (@(posedge clk) disable iff (rst)
    !(bigQ && smallQ));

endmodule

`default_nettype wire

// File: hw/fpCvtUnit.sv
/*
  Float to integer conversion unit, top level
  Issue control, operand unpack and the two-stage shifter
*/

`timescale 1ns/1ns
`default_nettype none

module fpCvtUnit
  import fpCvtPkg::*;
#(
  parameter int RES_W = fpCvtPkg::RES_W
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              valid,
  input  logic              stall,
  input  cvtOpE             op,
  input  logic [OPND_W-1:0] operand,
  output logic              resValid,
  output logic [RES_W-1:0]  result,
  output logic              overflow
);

  // Format flags, same cycle as the operand
  logic isSng;
  logic isDbl;
  logic isExt;
  logic isRaw;
  logic is32;

  // Unpacked operand
  logic                 sign;
  logic [EXT_MAN_W-1:0] mant;
  logic [6:0]           rshift;
  logic                 tooBig;
  logic                 tooSmall;

  cvtIssueCtrl cvtIssueCtrl_i (
    .clk      (clk),
    .rst      (rst),
    .valid    (valid),
    .stall    (stall),
    .op       (op),
    .isSng    (isSng),
    .isDbl    (isDbl),
    .isExt    (isExt),
    .isRaw    (isRaw),
    .is32Out  (is32),
    .resValid (resValid)
  );

  fpOperandUnpack fpOperandUnpack_i (
    .operand  (operand),
    .isSng    (isSng),
    .isDbl    (isDbl),
    .isExt    (isExt),
    .isRaw    (isRaw),
    .sign     (sign),
    .mant     (mant),
    .rshift   (rshift),
    .tooBig   (tooBig),
    .tooSmall (tooSmall)
  );

  fpToIntShifter fpToIntShifter_i (
    .clk      (clk),
    .rst      (rst),
    .stall    (stall),
    .is32     (is32),
    .sign     (sign),
    .mant     (mant),
    .rshift   (rshift),
    .tooBig   (tooBig),
    .tooSmall (tooSmall),
    .result   (result),
    .overflow (overflow)
  );

endmodule

`default_nettype wire

// File: verif/tbClock.sv
/*
  Clock and reset source of the testbench
*/

`timescale 1ns/1ns
`default_nettype none

module tbClock (
  output logic clk,
  output logic rst
);

  localparam int HALF = 10;  // 20 ns period

  initial begin
    clk = 1'b0;
    forever #HALF clk = ~clk;
  end

  // Three rising edges in reset, released between edges
  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

`default_nettype wire

// File: verif/cvtChecker.sv
/*
  Result checker of the conversion unit testbench
  Expected values from the test file, in-order compare, hold check under stall
*/

`timescale 1ns/1ns
`default_nettype none

module cvtChecker
  import fpCvtPkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             stall,
  input  logic             resValid,
  input  logic [RES_W-1:0] result,
  input  logic             overflow,
  input  int               issued,
  output int               checked,
  output int               valErrs,
  output int               otherErrs
);

  localparam int MAX_TESTS = 64;

  logic [151:0]     tests [MAX_TESTS];  // Opcode, operand, result, overflow
  int               numTests;
  int               issuedQ  = 0;
  logic             live     = 1'b0;    // Out of reset at the last rising edge
  logic             advanced = 1'b0;    // Pipe moved at the last rising edge
  logic [RES_W+1:0] prevOut  = '0;

  initial begin
    for (int i = 0; i < MAX_TESTS; i++) begin
      tests[i] = '1;  // Opcode nibble F ends the list
    end
    $readmemh("verif/cvtTests.mem", tests);
    numTests = 0;
    while (numTests < MAX_TESTS && tests[numTests][151:148] != 4'hF) begin
      numTests++;
    end
    checked   = 0;
    valErrs   = 0;
    otherErrs = 0;
  end

  always @(posedge clk) begin
    live     <= !rst;
    advanced <= !rst && !stall;
    issuedQ  <= issued;
  end

  task automatic compareNext();
    logic [RES_W-1:0] expRes;
    logic             expOvf;
    expRes = tests[checked][67:4];
    expOvf = tests[checked][0];
    if (result !== expRes) begin
      $display("[FAIL] test %0d result got %h expected %h", checked, result, expRes);
      valErrs++;
    end
    if (overflow !== expOvf) begin
      $display("[FAIL] test %0d overflow got %h expected %h", checked, overflow, expOvf);
      valErrs++;
    end
    checked++;
  endtask

  // ##############################
  // Compare at the falling edge
  // ##############################

  always @(negedge clk) begin
    if (live && !advanced && prevOut !== {resValid, overflow, result}) begin
      $display("Outputs changed during a stalled cycle");
      otherErrs++;
    end
    if (advanced && resValid) begin
      if (checked >= issuedQ || checked >= numTests) begin
        $display("Result arrived with no operation outstanding");
        otherErrs++;
      end else begin
        compareNext();
      end
    end
    prevOut = {resValid, overflow, result};
  end

endmodule

`default_nettype wire

// File: verif/fpCvtUnitTb.sv
/*
  Testbench top of the float to integer conversion unit
  Test file load, issue on falling edges with random gaps and stalls
*/

`timescale 1ns/1ns
`default_nettype none

module fpCvtUnitTb
  import fpCvtPkg::*;
();

  localparam int MAX_TESTS = 64;
  localparam int MAX_CYC   = 2000;

  logic              clk;
  logic              rst;
  logic              valid;
  logic              stall;
  cvtOpE             op;
  logic [OPND_W-1:0] operand;
  logic              resValid;
  logic [RES_W-1:0]  result;
  logic              overflow;

  logic [151:0] tests [MAX_TESTS];
  int           numTests;
  int           issued;
  int           checked;
  int           valErrs;
  int           otherErrs;
  int           tbErrs;
  int           seed;
  logic [31:0]  rnd;

  tbClock tbClock_i (.clk(clk), .rst(rst));

  fpCvtUnit #(.RES_W(RES_W)) fpCvtUnit_i (
    .clk(clk), .rst(rst), .valid(valid), .stall(stall), .op(op), .operand(operand),
    .resValid(resValid), .result(result), .overflow(overflow)
  );

  cvtChecker cvtChecker_i (
    .clk(clk), .rst(rst), .stall(stall), .resValid(resValid), .result(result),
    .overflow(overflow), .issued(issued), .checked(checked), .valErrs(valErrs),
    .otherErrs(otherErrs)
  );

  // ##############################
  // Stimulus tasks
  // ##############################

  task automatic holdUntilReset(input int limit);
    int n;
    n = 0;
    while (rst !== 1'b0 && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (rst !== 1'b0) begin
      $display("Reset was never released");
      tbErrs++;
    end
  endtask

  task automatic issueTests(input int limit);
    int n;
    n = 0;
    while (issued < numTests && n < limit) begin
      @(negedge clk);
      rnd   = $random(seed);
      valid = 1'b0;
      stall = (rnd[2:0] == 3'd0);  // Freeze with work in flight
      if (rnd[2:0] > 3'd1) begin   // 1 leaves an idle gap
        valid   = 1'b1;
        op      = cvtOpE'(tests[issued][150:148]);
        operand = tests[issued][147:68];
        issued++;
      end
      n++;
    end
    @(negedge clk);
    valid = 1'b0;
    stall = 1'b0;
    if (issued < numTests) begin
      $display("Could not issue all tests, %0d of %0d sent", issued, numTests);
      tbErrs++;
    end
  endtask

  task automatic drainPipe(input int limit);
    int n;
    n = 0;
    while (checked < numTests && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (checked < numTests) begin
      $display("Timed out with %0d of %0d results received", checked, numTests);
      tbErrs++;
    end
  endtask

  initial begin
    valid   = 1'b0;
    stall   = 1'b0;
    op      = opSngToI32;
    operand = '0;
    issued  = 0;
    tbErrs  = 0;
    seed    = 32'h428c9d43;
    for (int i = 0; i < MAX_TESTS; i++) begin
      tests[i] = '1;
    end
    $readmemh("verif/cvtTests.mem", tests);
    numTests = 0;
    while (numTests < MAX_TESTS && tests[numTests][151:148] != 4'hF) begin
      numTests++;
    end

    holdUntilReset(20);
    repeat (3) @(negedge clk);  // Idle after reset, nothing may complete
    issueTests(MAX_CYC);
    drainPipe(50);
    repeat (4) @(negedge clk);  // Window for stray or repeated results

    $display("Checked %0d of %0d, value errors %0d, other errors %0d",
             checked, numTests, valErrs, otherErrs + tbErrs);
    if (valErrs + otherErrs + tbErrs == 0 && numTests > 0 && checked == numTests) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: fpCvtUnit.f
hw/fpCvtPkg.sv
hw/cvtIssueCtrl.sv
hw/fpOperandUnpack.sv
hw/fpToIntShifter.sv
hw/fpCvtUnit.sv
verif/tbClock.sv
verif/cvtChecker.sv
verif/fpCvtUnitTb.sv

// File: run.sh
#!/bin/sh
# Build and run the fpCvtUnit testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module fpCvtUnitTb \
  -f fpCvtUnit.f --Mdir obj_dir -o fpCvtUnitSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/fpCvtUnitSim > "$LOG" 2>&1
simStatus=$?
cat "$LOG"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: verif/cvtTests.mem
// Opcode nibble _ operand in 20 hex digits _ expected result in 16 _ expected overflow
// Single and double operands sit in the low operand bits
1_0000000000003F800000_0000000000000001_0  // sng 1.0
1_0000000000004640E400_0000000000003039_0  // sng 12345.0
1_0000000000005E800000_4000000000000000_0  // sng 2^62
3_00003FF0000000000000_0000000000000001_0  // dbl 1.0
3_000040C81C8000000000_0000000000003039_0  // dbl 12345.0
3_000043D0000000000000_4000000000000000_0  // dbl 2^62
5_3FFF8000000000000000_0000000000000001_0  // ext 1.0
5_400CC0E4000000000000_0000000000003039_0  // ext 12345.0
5_403D8000000000000000_4000000000000000_0  // ext 2^62
3_0000C004000000000000_FFFFFFFFFFFFFFFD_0  // dbl -2.5
1_000000000000BE800000_FFFFFFFFFFFFFFFF_0  // sng -0.25
3_0000C0C81CE000000000_FFFFFFFFFFFFCFC6_0  // dbl -12345.75
5_C03DFFFFFFFFFFFFFFFF_8000000000000000_0  // ext just above -2^63
3_000043E0000000000000_0000000000000000_1  // dbl 2^63
1_0000000000007F800000_0000000000000000_1  // sng +Inf
3_00007FF8000000000000_0000000000000000_1  // dbl NaN
5_C03E8000000000000000_0000000000000000_1  // ext -2^63
1_00000000000000000000_0000000000000000_0  // sng zero
3_00003FE8000000000000_0000000000000000_0  // dbl 0.75
0_000000000000C640E600_00000000FFFFCFC6_0  // sng -12345.5 to i32
2_000041F0000000100000_0000000000000001_0  // dbl 2^32+1 to i32
4_BFFF8000000000000000_00000000FFFFFFFF_0  // ext -1.0 to i32
4_7FFF8000000000000000_0000000000000000_1  // ext +Inf to i32
6_ABCD0123456789ABCDEF_0123456789ABCDEF_0  // raw
